//--- source/memPkg.sv
package memPkg;

    // --------------------
    // Widths and sizes
    // --------------------
    localparam int XLEN        = 64;
    localparam int ADDR_W      = 64;
    localparam int STRB_W      = 8;
    localparam int OFFSET_W    = $clog2(STRB_W);
    localparam int REG_ADDR_W  = 5;
    localparam int CSR_ADDR_W  = 12;
    localparam int RAM_DEPTH   = 256;
    localparam int RAM_IDX_W   = $clog2(RAM_DEPTH);
    localparam int RAM_LATENCY = 2;
    localparam int RAM_CNT_W   = $clog2(RAM_LATENCY + 1);

    // Counter load value on request acceptance
    localparam logic [RAM_CNT_W-1:0] RAM_CNT_INIT = RAM_CNT_W'(RAM_LATENCY - 1);

    // Low two bits give log2 of the byte count, bit 2 marks zero extension
    typedef enum logic [2:0] {
        MEM_BYTE   = 3'b000,
        MEM_HALF   = 3'b001,
        MEM_WORD   = 3'b010,
        MEM_DOUBLE = 3'b011,
        MEM_BYTE_U = 3'b100,
        MEM_HALF_U = 3'b101,
        MEM_WORD_U = 3'b110
    } memMode_e;

    typedef enum logic [1:0] {
        MSIZE1 = 2'd0,
        MSIZE2 = 2'd1,
        MSIZE4 = 2'd2,
        MSIZE8 = 2'd3
    } msize_e;

    // --------------------
    // Data bus
    // --------------------
    typedef struct packed {
        logic                valid;
        logic [ADDR_W-1:0]   addr;
        msize_e              size;
        logic [STRB_W-1:0]   strobe;   // All zero for a read
        logic [XLEN-1:0]     data;
    } dbusReq_t;

    typedef struct packed {
        logic            addrOk;
        logic            dataOk;
        logic [XLEN-1:0] data;
    } dbusResp_t;

    // --------------------
    // Pipeline records
    // --------------------
    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       aluOut;
        logic [XLEN-1:0]       rs2;
        memMode_e              memMode;
        logic                  isMemRead;
        logic                  isMemWrite;
        logic                  isWriteBack;
        logic [REG_ADDR_W-1:0] wd;
        logic [ADDR_W-1:0]     pcPlus4;
        logic                  isCsrWrite;
        logic [CSR_ADDR_W-1:0] csrAddr;
        logic [XLEN-1:0]       csrWriteValue;
    } exMemReg_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       aluOut;
        logic [XLEN-1:0]       memOut;
        logic [ADDR_W-1:0]     pcPlus4;
        logic                  isWriteBack;
        logic                  isMemRead;
        logic                  isMem;
        logic [ADDR_W-1:0]     memAddr;
        logic [REG_ADDR_W-1:0] wd;
        logic                  isCsrWrite;
        logic [CSR_ADDR_W-1:0] csrAddr;
        logic [XLEN-1:0]       csrWriteValue;
    } memWbReg_t;

    typedef struct packed {
        logic                  valid;
        logic                  isWb;
        logic [REG_ADDR_W-1:0] wd;
        logic [XLEN-1:0]       wdData;
    } fwdSrc_t;

    typedef struct packed {
        logic                  valid;
        logic [CSR_ADDR_W-1:0] addr;
        logic [XLEN-1:0]       data;
    } csrFwdSrc_t;

endpackage

//--- source/storeAligner.sv
`timescale 1ns/1ps

module storeAligner (
    input  logic [memPkg::ADDR_W-1:0] addressReq,
    input  logic [memPkg::XLEN-1:0]   dataIn,
    input  memPkg::memMode_e          memMode,
    output logic [memPkg::ADDR_W-1:0] addr,
    output memPkg::msize_e            msize,
    output logic [memPkg::STRB_W-1:0] strobe,
    output logic [memPkg::XLEN-1:0]   data
);

    logic [memPkg::OFFSET_W-1:0] offset;
    logic [memPkg::STRB_W-1:0]   lanes;

    assign offset = addressReq[memPkg::OFFSET_W-1:0];
    assign addr   = addressReq;

    always_comb begin
        case (memMode)
            memPkg::MEM_BYTE, memPkg::MEM_BYTE_U: begin
                msize = memPkg::MSIZE1;
                lanes = 8'h01;
            end
            memPkg::MEM_HALF, memPkg::MEM_HALF_U: begin
                msize = memPkg::MSIZE2;
                lanes = 8'h03;
            end
            memPkg::MEM_WORD, memPkg::MEM_WORD_U: begin
                msize = memPkg::MSIZE4;
                lanes = 8'h0f;
            end
            default: begin
                msize = memPkg::MSIZE8;
                lanes = 8'hff;
            end
        endcase
    end

    // Move bytes into the lanes picked by the byte offset
    assign strobe = lanes << offset;
    assign data   = dataIn << {offset, 3'b000};

endmodule

//--- source/loadExtractor.sv
`timescale 1ns/1ps

module loadExtractor (
    input  logic [memPkg::ADDR_W-1:0] addressReq,
    input  logic [memPkg::XLEN-1:0]   dataIn,
    input  memPkg::memMode_e          memMode,
    output logic [memPkg::XLEN-1:0]   data
);

    logic [memPkg::XLEN-1:0] shifted;

    // Addressed bytes end up in the low lanes
    assign shifted = dataIn >> {addressReq[memPkg::OFFSET_W-1:0], 3'b000};

    always_comb begin
        case (memMode)
            memPkg::MEM_BYTE:
                data = {{(memPkg::XLEN - 8){shifted[7]}}, shifted[7:0]};
            memPkg::MEM_HALF:
                data = {{(memPkg::XLEN - 16){shifted[15]}}, shifted[15:0]};
            memPkg::MEM_WORD:
                data = {{(memPkg::XLEN - 32){shifted[31]}}, shifted[31:0]};
            memPkg::MEM_BYTE_U:
                data = {{(memPkg::XLEN - 8){1'b0}}, shifted[7:0]};
            memPkg::MEM_HALF_U:
                data = {{(memPkg::XLEN - 16){1'b0}}, shifted[15:0]};
            memPkg::MEM_WORD_U:
                data = {{(memPkg::XLEN - 32){1'b0}}, shifted[31:0]};
            default:
                data = shifted;
        endcase
    end

endmodule

//--- source/memStage.sv
`timescale 1ns/1ps

module memStage (
    input  logic               clk,
    input  logic               rst,
    input  memPkg::exMemReg_t  moduleIn,
    output memPkg::memWbReg_t  moduleOut,
    output memPkg::fwdSrc_t    fwdSrc,
    output memPkg::csrFwdSrc_t csrFwdSrc,
    output memPkg::dbusReq_t   dreq,
    input  memPkg::dbusResp_t  dresp,
    output logic               okToProceed,
    input  logic               okToProceedOverall
);

    logic                        isMemOp;
    logic                        started;
    logic                        done;
    logic                        respHit;
    logic                        startHit;
    logic [memPkg::XLEN-1:0]     memData;
    logic [memPkg::XLEN-1:0]     loadData;
    logic [memPkg::ADDR_W-1:0]   alignedAddr;
    memPkg::msize_e              alignedSize;
    logic [memPkg::STRB_W-1:0]   alignedStrobe;
    logic [memPkg::XLEN-1:0]     alignedData;

    assign isMemOp     = moduleIn.isMemRead | moduleIn.isMemWrite;
    assign okToProceed = ~moduleIn.valid | ~isMemOp | done;
    assign respHit     = dresp.addrOk & dresp.dataOk & started;
    assign startHit    = moduleIn.valid & isMemOp & ~started;

    storeAligner i_align (
        .addressReq (moduleIn.aluOut),
        .dataIn     (moduleIn.rs2),
        .memMode    (moduleIn.memMode),
        .addr       (alignedAddr),
        .msize      (alignedSize),
        .strobe     (alignedStrobe),
        .data       (alignedData)
    );

    loadExtractor i_extract (
        .addressReq (moduleIn.aluOut),
        .dataIn     (memData),
        .memMode    (moduleIn.memMode),
        .data       (loadData)
    );

    // --------------------
    // Forwarding
    // --------------------
    assign fwdSrc.valid  = moduleIn.valid & (moduleIn.wd != '0);
    assign fwdSrc.isWb   = moduleIn.isWriteBack;
    assign fwdSrc.wd     = moduleIn.wd;
    assign fwdSrc.wdData = moduleIn.isMemRead ? loadData : moduleIn.aluOut;

    assign csrFwdSrc.valid = moduleIn.valid & moduleIn.isCsrWrite;
    assign csrFwdSrc.addr  = moduleIn.csrAddr;
    assign csrFwdSrc.data  = moduleIn.csrWriteValue;

    // --------------------
    // Bus sequencing
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dreq    <= '0;
            started <= 1'b0;
            done    <= 1'b0;
        end else begin
            // Record leaves the stage, arm for the next one
            if (okToProceedOverall) begin
                started <= 1'b0;
                done    <= 1'b0;
            end
            if (respHit) begin
                done       <= 1'b1;
                dreq.valid <= 1'b0;
            end
            if (startHit) begin
                started    <= 1'b1;
                dreq.valid <= 1'b1;
                dreq.addr  <= alignedAddr;
                dreq.size  <= alignedSize;
                dreq.data  <= alignedData;
                dreq.strobe <= moduleIn.isMemRead ? '0 : alignedStrobe;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (respHit) begin
            memData <= dresp.data;
        end
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            moduleOut <= '0;
        end else if (okToProceedOverall) begin
            moduleOut.valid         <= moduleIn.valid;
            moduleOut.aluOut        <= moduleIn.aluOut;
            moduleOut.memOut        <= loadData;
            moduleOut.pcPlus4       <= moduleIn.pcPlus4;
            moduleOut.isWriteBack   <= moduleIn.isWriteBack;
            moduleOut.isMemRead     <= moduleIn.isMemRead;
            moduleOut.isMem         <= isMemOp;
            moduleOut.memAddr       <= moduleIn.aluOut;
            moduleOut.wd            <= moduleIn.wd;
            moduleOut.isCsrWrite    <= moduleIn.isCsrWrite;
            moduleOut.csrAddr       <= moduleIn.csrAddr;
            moduleOut.csrWriteValue <= moduleIn.csrWriteValue;
        end
    end

endmodule

//--- source/dataRam.sv
`timescale 1ns/1ps

module dataRam (
    input  logic              clk,
    input  logic              rst,
    input  memPkg::dbusReq_t  dreq,
    output memPkg::dbusResp_t dresp
);

    logic [memPkg::XLEN-1:0]      mem [memPkg::RAM_DEPTH] = '{default: '0};
    memPkg::dbusReq_t             reqQ;
    logic                         validQ;
    logic                         busy;
    logic [memPkg::RAM_CNT_W-1:0] cnt;
    logic                         accept;
    logic                         fire;
    logic [memPkg::RAM_IDX_W-1:0] idx;

    // New request only on a rising valid while idle
    assign accept = dreq.valid & ~validQ & ~busy;
    assign fire   = busy & (cnt <= 1);
    assign idx    = reqQ.addr[memPkg::OFFSET_W +: memPkg::RAM_IDX_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
            busy   <= 1'b0;
            cnt    <= '0;
            dresp  <= '0;
        end else begin
            validQ       <= dreq.valid;
            dresp.addrOk <= 1'b0;
            dresp.dataOk <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                cnt  <= memPkg::RAM_CNT_INIT;
            end else if (fire) begin
                busy         <= 1'b0;
                dresp.addrOk <= 1'b1;
                dresp.dataOk <= 1'b1;
                dresp.data   <= mem[idx];   // old content, also for writes
            end else if (busy) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    // --------------------
    // Request latch and byte writes
    // --------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            reqQ <= dreq;
        end
        if (fire) begin
            for (int lane = 0; lane < memPkg::STRB_W; lane++) begin
                if (reqQ.strobe[lane]) begin
                    mem[idx][8*lane +: 8] <= reqQ.data[8*lane +: 8];
                end
            end
        end
    end

endmodule

//--- source/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem (
    input  logic               clk,
    input  logic               rst,
    input  memPkg::exMemReg_t  moduleIn,
    input  logic               okToProceedOverall,
    output memPkg::memWbReg_t  moduleOut,
    output memPkg::fwdSrc_t    fwdSrc,
    output memPkg::csrFwdSrc_t csrFwdSrc,
    output logic               okToProceed
);

    memPkg::dbusReq_t  dreq;
    memPkg::dbusResp_t dresp;

    memStage i_stage (
        .clk                (clk),
        .rst                (rst),
        .moduleIn           (moduleIn),
        .moduleOut          (moduleOut),
        .fwdSrc             (fwdSrc),
        .csrFwdSrc          (csrFwdSrc),
        .dreq               (dreq),
        .dresp              (dresp),
        .okToProceed        (okToProceed),
        .okToProceedOverall (okToProceedOverall)
    );

    // Stands in for the data cache
    dataRam i_ram (
        .clk   (clk),
        .rst   (rst),
        .dreq  (dreq),
        .dresp (dresp)
    );

endmodule

//--- dv/memSubsystem_sva.sv
`timescale 1ns/1ps

module memSubsystemSva (
    input logic              clk,
    input logic              rst,
    input memPkg::exMemReg_t moduleIn,
    input memPkg::dbusReq_t  dreq,
    input memPkg::dbusResp_t dresp,
    input logic              okToProceed
);

    logic respSeen;

    assign respSeen = dresp.addrOk & dresp.dataOk;

    // No bus request while in reset
    resetIdle: assert property (@(posedge clk) rst |-> !dreq.valid)
        else $error("bus request is valid during reset");

    // Non-memory record passes at once and starts no bus request
    nonMemProceeds: assert property (@(posedge clk) disable iff (rst)
        (moduleIn.valid && !moduleIn.isMemRead && !moduleIn.isMemWrite && !dreq.valid)
            |-> okToProceed ##1 !dreq.valid)
        else $error("stage stalls or requests the bus on a record without memory access");

    // Request is a level until the response arrives
    reqHeld: assert property (@(posedge clk) disable iff (rst)
        (dreq.valid && !respSeen) |=>
            (dreq.valid && $stable(dreq.addr) && $stable(dreq.size) &&
             $stable(dreq.strobe) && $stable(dreq.data)))
        else $error("bus request changed or dropped before its response");

endmodule

bind memStage memSubsystemSva i_sva (
    .clk         (clk),
    .rst         (rst),
    .moduleIn    (moduleIn),
    .dreq        (dreq),
    .dresp       (dresp),
    .okToProceed (okToProceed)
);

//--- dv/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int SEED      = 63128;
    localparam int OP_LOAD   = 0;
    localparam int OP_STORE  = 1;
    localparam int OP_ALU    = 2;
    localparam int OP_CSR    = 3;
    localparam int MEM_BYTES = memPkg::RAM_DEPTH * memPkg::STRB_W;

    typedef struct {
        string            name;
        int               op;
        logic [63:0]      addr;
        logic [63:0]      data;
        memPkg::memMode_e mode;
        logic [4:0]       wd;
        logic [63:0]      pc;
        logic [11:0]      csrAddr;
        logic [63:0]      csrVal;
    } testEntry_t;

    logic               clk;
    logic               rst;
    memPkg::exMemReg_t  moduleIn;
    logic               okToProceedOverall;
    memPkg::memWbReg_t  moduleOut;
    memPkg::fwdSrc_t    fwdSrc;
    memPkg::csrFwdSrc_t csrFwdSrc;
    logic               okToProceed;

    testEntry_t testTable[$];
    logic [7:0] refMem [MEM_BYTES];
    int         cycleCount = 0;
    int         cycleLimit = 0;

    // Rest of the pipeline lets a record go as soon as this stage is ready
    assign okToProceedOverall = okToProceed;

    memSubsystem i_dut (
        .clk                (clk),
        .rst                (rst),
        .moduleIn           (moduleIn),
        .okToProceedOverall (okToProceedOverall),
        .moduleOut          (moduleOut),
        .fwdSrc             (fwdSrc),
        .csrFwdSrc          (csrFwdSrc),
        .okToProceed        (okToProceed)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the design stalled, no progress after %0d cycles", cycleCount);
            $display("=== FAIL ===");
            $fatal(1, "run stopped on timeout");
        end
    end

    task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // --------------------
    // Reference memory
    // --------------------
    function automatic int accessBytes(memPkg::memMode_e mode);
        return 1 << mode[1:0];
    endfunction

    function automatic logic [63:0] expectLoad(logic [63:0] addr, memPkg::memMode_e mode);
        int          nBytes;
        int          base;
        logic [63:0] value;
        nBytes = accessBytes(mode);
        base   = int'(addr[31:0]) % MEM_BYTES;
        value  = '0;
        for (int b = 0; b < nBytes; b++) begin
            value[8*b +: 8] = refMem[(base + b) % MEM_BYTES];
        end
        // Signed modes copy the top accessed bit upward
        if (!mode[2] && nBytes < 8 && value[8*nBytes-1]) begin
            value = value | ~((64'h1 << (8 * nBytes)) - 64'h1);
        end
        return value;
    endfunction

    task automatic storeRef(logic [63:0] addr, logic [63:0] data, memPkg::memMode_e mode);
        int base;
        base = int'(addr[31:0]) % MEM_BYTES;
        for (int b = 0; b < accessBytes(mode); b++) begin
            refMem[(base + b) % MEM_BYTES] = data[8*b +: 8];
        end
    endtask

    // --------------------
    // Stimulus table
    // --------------------
    function automatic memPkg::exMemReg_t makeRecord(testEntry_t e);
        memPkg::exMemReg_t rec;
        rec               = '0;
        rec.valid         = 1'b1;
        rec.aluOut        = (e.op == OP_LOAD || e.op == OP_STORE) ? e.addr : e.data;
        rec.rs2           = e.data;
        rec.memMode       = e.mode;
        rec.isMemRead     = (e.op == OP_LOAD);
        rec.isMemWrite    = (e.op == OP_STORE);
        rec.isWriteBack   = (e.op == OP_LOAD || e.op == OP_ALU);
        rec.wd            = e.wd;
        rec.pcPlus4       = e.pc;
        rec.isCsrWrite    = (e.op == OP_CSR);
        rec.csrAddr       = e.csrAddr;
        rec.csrWriteValue = e.csrVal;
        return rec;
    endfunction

    task automatic addEntry(string name, int op, logic [63:0] addr, logic [63:0] data,
                            memPkg::memMode_e mode, logic [4:0] wd);
        testEntry_t e;
        e.name    = name;
        e.op      = op;
        e.addr    = addr;
        e.data    = data;
        e.mode    = mode;
        e.wd      = wd;
        e.pc      = {$urandom, $urandom};
        e.csrAddr = 12'($urandom);
        e.csrVal  = {$urandom, $urandom};
        testTable.push_back(e);
    endtask

    // Naturally aligned address anywhere in the RAM
    function automatic logic [63:0] randAddr(memPkg::memMode_e mode);
        int word;
        int off;
        word = int'($urandom % 256);
        off  = (int'($urandom % 8) / accessBytes(mode)) * accessBytes(mode);
        return 64'(word * 8 + off);
    endfunction

    task automatic buildTable();
        logic [63:0]      a0;
        logic [63:0]      a1;
        memPkg::memMode_e mode;
        memPkg::memMode_e ldMode;
        logic [63:0]      addr;
        a0 = 64'h100;
        a1 = 64'h208;
        addEntry("alu", OP_ALU, '0, {$urandom, $urandom}, memPkg::MEM_DOUBLE, 5'd7);
        addEntry("alu_wd0", OP_ALU, '0, {$urandom, $urandom}, memPkg::MEM_DOUBLE, 5'd0);
        addEntry("csr", OP_CSR, '0, {$urandom, $urandom}, memPkg::MEM_DOUBLE, 5'd0);
        addEntry("st_d", OP_STORE, a0, {$urandom, $urandom}, memPkg::MEM_DOUBLE, 5'd0);
        addEntry("ld_d", OP_LOAD, a0, '0, memPkg::MEM_DOUBLE, 5'd10);
        addEntry("st_b", OP_STORE, a0 + 3, {$urandom, $urandom} | 64'h80,
                 memPkg::MEM_BYTE, 5'd0);
        addEntry("ld_b", OP_LOAD, a0 + 3, '0, memPkg::MEM_BYTE, 5'd11);
        addEntry("ld_bu", OP_LOAD, a0 + 3, '0, memPkg::MEM_BYTE_U, 5'd12);
        addEntry("st_h", OP_STORE, a0 + 6, {$urandom, $urandom} | 64'h8000,
                 memPkg::MEM_HALF, 5'd0);
        addEntry("ld_h", OP_LOAD, a0 + 6, '0, memPkg::MEM_HALF, 5'd13);
        addEntry("ld_hu", OP_LOAD, a0 + 6, '0, memPkg::MEM_HALF_U, 5'd14);
        // Neighbor bytes of the narrow stores must survive
        addEntry("ld_d_nb", OP_LOAD, a0, '0, memPkg::MEM_DOUBLE, 5'd15);
        addEntry("st_d1", OP_STORE, a1, {$urandom, $urandom}, memPkg::MEM_DOUBLE, 5'd0);
        addEntry("st_w", OP_STORE, a1 + 4, {$urandom, $urandom} | 64'h8000_0000,
                 memPkg::MEM_WORD, 5'd0);
        addEntry("ld_w", OP_LOAD, a1 + 4, '0, memPkg::MEM_WORD, 5'd16);
        addEntry("ld_wu", OP_LOAD, a1 + 4, '0, memPkg::MEM_WORD_U, 5'd17);
        addEntry("ld_d1", OP_LOAD, a1, '0, memPkg::MEM_DOUBLE, 5'd18);
        addEntry("ld_zero", OP_LOAD, 64'h7f8, '0, memPkg::MEM_DOUBLE, 5'd0);
        for (int i = 0; i < 12; i++) begin
            mode   = memPkg::memMode_e'(3'($urandom % 7));
            ldMode = (mode == memPkg::MEM_DOUBLE) ? mode : memPkg::memMode_e'(mode ^ 3'b100);
            addr   = randAddr(mode);
            addEntry($sformatf("rnd_st%0d", i), OP_STORE, addr, {$urandom, $urandom},
                     mode, 5'd0);
            addEntry($sformatf("rnd_ld%0d", i), OP_LOAD, addr, '0, ldMode,
                     5'($urandom % 31 + 1));
        end
    endtask

    // --------------------
    // Checks per record
    // --------------------
    task automatic checkForward(testEntry_t e, logic [63:0] expLoad);
        memPkg::exMemReg_t rec;
        logic [63:0]       expData;
        rec     = makeRecord(e);
        expData = (e.op == OP_LOAD) ? expLoad : rec.aluOut;
        checkValue({e.name, " fwd.valid"}, 64'(e.wd != 5'd0), 64'(fwdSrc.valid));
        checkValue({e.name, " fwd.isWb"}, 64'(rec.isWriteBack), 64'(fwdSrc.isWb));
        if (e.wd != 5'd0) begin
            checkValue({e.name, " fwd.wd"}, 64'(e.wd), 64'(fwdSrc.wd));
            checkValue({e.name, " fwd.wdData"}, expData, fwdSrc.wdData);
        end
        checkValue({e.name, " csrFwd.valid"}, 64'(e.op == OP_CSR), 64'(csrFwdSrc.valid));
        if (e.op == OP_CSR) begin
            checkValue({e.name, " csrFwd.addr"}, 64'(e.csrAddr), 64'(csrFwdSrc.addr));
            checkValue({e.name, " csrFwd.data"}, e.csrVal, csrFwdSrc.data);
        end
    endtask

    task automatic checkOutput(testEntry_t e, logic [63:0] expLoad);
        memPkg::exMemReg_t rec;
        rec = makeRecord(e);
        checkValue({e.name, " out.valid"}, 64'(1), 64'(moduleOut.valid));
        checkValue({e.name, " out.aluOut"}, rec.aluOut, moduleOut.aluOut);
        checkValue({e.name, " out.pcPlus4"}, e.pc, moduleOut.pcPlus4);
        checkValue({e.name, " out.wd"}, 64'(e.wd), 64'(moduleOut.wd));
        checkValue({e.name, " out.isWriteBack"}, 64'(rec.isWriteBack),
                   64'(moduleOut.isWriteBack));
        checkValue({e.name, " out.isMemRead"}, 64'(rec.isMemRead),
                   64'(moduleOut.isMemRead));
        checkValue({e.name, " out.isMem"}, 64'(rec.isMemRead | rec.isMemWrite),
                   64'(moduleOut.isMem));
        checkValue({e.name, " out.isCsrWrite"}, 64'(rec.isCsrWrite), 64'(moduleOut.isCsrWrite));
        checkValue({e.name, " out.csrAddr"}, 64'(e.csrAddr), 64'(moduleOut.csrAddr));
        checkValue({e.name, " out.csrWriteValue"}, e.csrVal, moduleOut.csrWriteValue);
        if (e.op == OP_LOAD || e.op == OP_STORE) begin
            checkValue({e.name, " out.memAddr"}, e.addr, moduleOut.memAddr);
        end
        if (e.op == OP_LOAD) begin
            checkValue({e.name, " out.memOut"}, expLoad, moduleOut.memOut);
        end
    endtask

    initial begin
        memPkg::exMemReg_t idle;
        testEntry_t        e;
        logic [63:0]       expLoad;
        void'($urandom(SEED));
        idle     = '0;
        rst      = 1'b1;
        moduleIn = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            refMem[i] = 8'h00;
        end
        buildTable();
        cycleLimit = testTable.size() * (memPkg::RAM_LATENCY + 6) + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        checkValue("reset_during", 64'(0), 64'(moduleOut.valid));
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("reset_after", 64'(0), 64'(moduleOut.valid));

        @(posedge clk);
        moduleIn <= makeRecord(testTable[0]);
        @(negedge clk);
        for (int i = 0; i < testTable.size(); i++) begin
            e       = testTable[i];
            expLoad = expectLoad(e.addr, e.mode);
            if (e.op == OP_ALU || e.op == OP_CSR) begin
                checkValue({e.name, " okToProceed"}, 64'(1), 64'(okToProceed));
            end
            while (!okToProceed) @(negedge clk);
            checkForward(e, expLoad);
            // Next record goes in on the same edge that retires this one
            @(posedge clk);
            if (i + 1 < testTable.size()) begin
                moduleIn <= makeRecord(testTable[i + 1]);
            end else begin
                moduleIn <= idle;
            end
            @(negedge clk);
            checkOutput(e, expLoad);
            if (e.op == OP_STORE) begin
                storeRef(e.addr, e.data, e.mode);
            end
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- memSubsystem.f
source/memPkg.sv
source/storeAligner.sv
source/loadExtractor.sv
source/memStage.sv
source/dataRam.sv
source/memSubsystem.sv
dv/memSubsystem_sva.sv
dv/memSubsystemTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= memSubsystemTb
FILELIST  ?= memSubsystem.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
